// ==== source/fixedPointPkg.sv ====
package fixedPointPkg;

  //////////////////////////////////////////////////
  // Scalar formats
  //////////////////////////////////////////////////

  // Two's complement sample component
  typedef logic signed [15:0] sampleT;

  // Q1.14 twiddle component, 0x4000 is +1.0
  typedef logic signed [15:0] coefT;

  // Sum of two full-width products plus one guard bit
  typedef logic signed [32:0] productT;

  localparam int FRAC_BITS = 14;

  //////////////////////////////////////////////////
  // Complex pairs
  //////////////////////////////////////////////////

  typedef struct packed {
    sampleT re;
    sampleT im;
  } complexT;

  typedef struct packed {
    coefT cos;
    coefT sin;
  } twiddleT;

endpackage

// ==== source/rotatorCtrlPkg.sv ====
package rotatorCtrlPkg;

  // Points per FFT frame
  localparam int FRAME_LEN = 24;

  typedef logic [4:0] indexT;

  //////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////

  // Indexer to table lookup
  typedef struct packed {
    logic                   valid;
    logic                   frameStart;
    indexT                  index;
    fixedPointPkg::complexT sample;
  } indexedT;

  // Table lookup to multiplier
  typedef struct packed {
    logic                   valid;
    logic                   frameStart;
    fixedPointPkg::complexT sample;
    fixedPointPkg::twiddleT twiddle;
  } weightedT;

endpackage

// ==== source/sampleIndexer.sv ====
`timescale 1ns/10ps

module sampleIndexer
  (
  input  logic                    CLK,
  input  logic                    ARST,
  input  logic                    inValid,
  input  fixedPointPkg::complexT  inSample,
  output rotatorCtrlPkg::indexedT stageOut
  );

  import rotatorCtrlPkg::*;

  indexT frameIndex;

  // Frame counter, only accepted samples move it
  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      frameIndex <= '0;
    end
    else if (inValid)
    begin
      if (frameIndex == indexT'(FRAME_LEN - 1))
      begin
        frameIndex <= '0;
      end
      else
      begin
        frameIndex <= frameIndex + 1'b1;
      end
    end
  end

  // Tag sample with the index it consumed
  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      stageOut <= '0;
    end
    else
    begin
      stageOut.valid      <= inValid;
      stageOut.frameStart <= inValid && (frameIndex == '0);
      stageOut.index      <= frameIndex;
      stageOut.sample     <= inSample;
    end
  end

  indexInRange : assert property (@(posedge CLK) disable iff (ARST)
    frameIndex <= indexT'(FRAME_LEN - 1));

endmodule

// ==== source/twiddleRom.sv ====
`timescale 1ns/10ps

module twiddleRom
  (
  input  logic                     CLK,
  input  logic                     ARST,
  input  rotatorCtrlPkg::indexedT  stageIn,
  output rotatorCtrlPkg::weightedT stageOut
  );

  import fixedPointPkg::*;

  twiddleT coefLookup;

  //////////////////////////////////////////////////
  // Twiddle table in Q1.14
  //////////////////////////////////////////////////

  always_comb
  begin
    case (stageIn.index)
      5'd0:    coefLookup = '{cos: 16'h4000, sin: 16'h0000};
      5'd1:    coefLookup = '{cos: 16'hEF70, sin: 16'h3DD1};
      5'd2:    coefLookup = '{cos: 16'hC894, sin: 16'hE001};
      5'd3:    coefLookup = '{cos: 16'h2D41, sin: 16'hD2BF};
      5'd4:    coefLookup = '{cos: 16'h2000, sin: 16'h376C};
      5'd5:    coefLookup = '{cos: 16'hC22F, sin: 16'h1090};
      // Quarter turn with sin = -1
      5'd6:    coefLookup = '{cos: 16'h0000, sin: 16'hC000};
      5'd7:    coefLookup = '{cos: 16'h3DD1, sin: 16'h1090};
      5'd8:    coefLookup = '{cos: 16'hE001, sin: 16'h376C};
      5'd9:    coefLookup = '{cos: 16'hD2BF, sin: 16'hD2BF};
      5'd10:   coefLookup = '{cos: 16'h376C, sin: 16'hE000};
      5'd11:   coefLookup = '{cos: 16'h1090, sin: 16'h3DD1};
      5'd12:   coefLookup = '{cos: 16'hC000, sin: 16'h0000};
      5'd13:   coefLookup = '{cos: 16'h1090, sin: 16'hC22F};
      5'd14:   coefLookup = '{cos: 16'h376C, sin: 16'h1FFF};
      5'd15:   coefLookup = '{cos: 16'hD2BF, sin: 16'h2D41};
      5'd16:   coefLookup = '{cos: 16'hE000, sin: 16'hC894};
      5'd17:   coefLookup = '{cos: 16'h3DD1, sin: 16'hEF70};
      5'd18:   coefLookup = '{cos: 16'h0000, sin: 16'h4000};
      5'd19:   coefLookup = '{cos: 16'hC22F, sin: 16'hEF70};
      5'd20:   coefLookup = '{cos: 16'h1FFF, sin: 16'hC894};
      // Diagonal with both near 0.7071
      5'd21:   coefLookup = '{cos: 16'h2D41, sin: 16'h2D41};
      5'd22:   coefLookup = '{cos: 16'hC894, sin: 16'h2000};
      5'd23:   coefLookup = '{cos: 16'hEF70, sin: 16'hC22F};
      default: coefLookup = '{cos: 16'h0000, sin: 16'h0000};
    endcase
  end

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  // Sample leaves in step with its coefficients
  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      stageOut <= '0;
    end
    else
    begin
      stageOut <= '{valid:      stageIn.valid,
                    frameStart: stageIn.frameStart,
                    sample:     stageIn.sample,
                    twiddle:    coefLookup};
    end
  end

endmodule

// ==== source/complexMultiplier.sv ====
`timescale 1ns/10ps

module complexMultiplier
  (
  input  logic                     CLK,
  input  logic                     ARST,
  input  rotatorCtrlPkg::weightedT stageIn,
  output logic                     outValid,
  output logic                     outFrameStart,
  output fixedPointPkg::complexT   outSample
  );

  import fixedPointPkg::*;

  typedef logic signed [2*$bits(sampleT)-1:0] partialT;

  localparam productT satHigh = 33'sd32767;
  localparam productT satLow  = -33'sd32768;

  partialT reCos;
  partialT imSin;
  partialT reSin;
  partialT imCos;
  logic    prodValid;
  logic    prodFrameStart;
  productT reSum;
  productT imSum;

  // Round half up, then clamp to the sample range
  function automatic sampleT roundSat(input productT sum);
    productT rounded;
    rounded = (sum + productT'(2 ** (FRAC_BITS - 1))) >>> FRAC_BITS;
    if (rounded > satHigh)
      roundSat = sampleT'(satHigh);
    else if (rounded < satLow)
      roundSat = sampleT'(satLow);
    else
      roundSat = sampleT'(rounded);
  endfunction

  //////////////////////////////////////////////////
  // Stage 3, partial products
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      prodValid      <= 1'b0;
      prodFrameStart <= 1'b0;
      reCos          <= '0;
      imSin          <= '0;
      reSin          <= '0;
      imCos          <= '0;
    end
    else
    begin
      prodValid      <= stageIn.valid;
      prodFrameStart <= stageIn.frameStart;
      reCos          <= stageIn.sample.re * stageIn.twiddle.cos;
      imSin          <= stageIn.sample.im * stageIn.twiddle.sin;
      reSin          <= stageIn.sample.re * stageIn.twiddle.sin;
      imCos          <= stageIn.sample.im * stageIn.twiddle.cos;
    end
  end

  //////////////////////////////////////////////////
  // Stage 4, sum, round and saturate
  //////////////////////////////////////////////////

  always_comb
  begin
    reSum = productT'(reCos) - productT'(imSin);
    imSum = productT'(reSin) + productT'(imCos);
  end

  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      outValid      <= 1'b0;
      outFrameStart <= 1'b0;
      outSample     <= '0;
    end
    else
    begin
      outValid      <= prodValid;
      outFrameStart <= prodFrameStart;
      outSample     <= '{re: roundSat(reSum), im: roundSat(imSum)};
    end
  end

  validLatency : assert property (@(posedge CLK) disable iff (ARST)
    outValid == $past(stageIn.valid, 2));

endmodule

// ==== source/twiddleRotator.sv ====
`timescale 1ns/10ps

module twiddleRotator
  (
  input  logic                   CLK,
  input  logic                   ARST,
  input  logic                   inValid,
  input  fixedPointPkg::complexT inSample,
  output logic                   outValid,
  output fixedPointPkg::complexT outSample,
  output logic                   outFrameStart
  );

  import rotatorCtrlPkg::*;

  //////////////////////////////////////////////////
  // Stage buses
  //////////////////////////////////////////////////

  indexedT  indexedBus;
  weightedT weightedBus;

  // Index assignment
  sampleIndexer sampleIndexer_i
    (
    .CLK      (CLK),
    .ARST     (ARST),
    .inValid  (inValid),
    .inSample (inSample),
    .stageOut (indexedBus)
    );

  // Coefficient lookup
  twiddleRom twiddleRom_i
    (
    .CLK      (CLK),
    .ARST     (ARST),
    .stageIn  (indexedBus),
    .stageOut (weightedBus)
    );

  // Products, then round and saturate
  complexMultiplier complexMultiplier_i
    (
    .CLK           (CLK),
    .ARST          (ARST),
    .stageIn       (weightedBus),
    .outValid      (outValid),
    .outFrameStart (outFrameStart),
    .outSample     (outSample)
    );

endmodule

// ==== verif/twiddleRotatorTb.sv ====
`timescale 1ns/10ps

module twiddleRotatorTb;

  import fixedPointPkg::*;
  import rotatorCtrlPkg::*;

  typedef struct packed {
    indexT   index;
    complexT sample;
  } pendingT;

  localparam longint roundBias = longint'(1) << (FRAC_BITS - 1);

  // cos in the upper half, sin in the lower half
  localparam logic [31:0] refTable [0:FRAME_LEN-1] = '{
    32'h4000_0000, 32'hEF70_3DD1, 32'hC894_E001, 32'h2D41_D2BF,
    32'h2000_376C, 32'hC22F_1090, 32'h0000_C000, 32'h3DD1_1090,
    32'hE001_376C, 32'hD2BF_D2BF, 32'h376C_E000, 32'h1090_3DD1,
    32'hC000_0000, 32'h1090_C22F, 32'h376C_1FFF, 32'hD2BF_2D41,
    32'hE000_C894, 32'h3DD1_EF70, 32'h0000_4000, 32'hC22F_EF70,
    32'h1FFF_C894, 32'h2D41_2D41, 32'hC894_2000, 32'hEF70_C22F
  };

  logic    CLK;
  logic    ARST;
  logic    inValid;
  complexT inSample;
  logic    outValid;
  complexT outSample;
  logic    outFrameStart;

  pendingT expQ [$];
  pendingT entry;
  indexT   modelIndex;
  complexT probe;

  twiddleRotator twiddleRotator_i
    (
    .CLK           (CLK),
    .ARST          (ARST),
    .inValid       (inValid),
    .inSample      (inSample),
    .outValid      (outValid),
    .outSample     (outSample),
    .outFrameStart (outFrameStart)
    );

  initial
  begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic sampleT clampSample(input longint value);
    if (value > 32767)
      return sampleT'(32767);
    else if (value < -32768)
      return sampleT'(-32768);
    else
      return sampleT'(value);
  endfunction

  function automatic complexT rotateRef(input complexT s, input indexT idx);
    twiddleT w;
    longint  reAcc;
    longint  imAcc;
    w = twiddleT'(refTable[idx]);
    reAcc = longint'(s.re) * longint'(w.cos) - longint'(s.im) * longint'(w.sin);
    imAcc = longint'(s.re) * longint'(w.sin) + longint'(s.im) * longint'(w.cos);
    rotateRef.re = clampSample((reAcc + roundBias) >>> FRAC_BITS);
    rotateRef.im = clampSample((imAcc + roundBias) >>> FRAC_BITS);
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic stopRun;
    $display("TEST FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic compareSample(input string name, input complexT got, input complexT exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got re=%0d im=%0d expected re=%0d im=%0d",
               $time, name, got.re, got.im, exp.re, exp.im);
      stopRun();
    end
  endtask

  task automatic compareFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      stopRun();
    end
  endtask

  // Outputs are read mid-cycle, away from the active edge
  always @(negedge CLK)
  begin
    if (!ARST && outValid)
    begin
      if (expQ.size() == 0)
      begin
        $display("Output strobe at %0t with no sample pending", $time);
        stopRun();
      end
      else
      begin
        entry = expQ.pop_front();
        compareSample("outSample", outSample, rotateRef(entry.sample, entry.index));
        compareFlag("outFrameStart", outFrameStart, entry.index == '0);
      end
    end
    else
    begin
      compareFlag("outFrameStart", outFrameStart, 1'b0);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  function automatic complexT randomSample();
    randomSample.re = sampleT'($urandom);
    randomSample.im = sampleT'($urandom);
  endfunction

  task automatic driveSample(input complexT s);
    @(posedge CLK);
    inValid  <= 1'b1;
    inSample <= s;
    expQ.push_back('{index: modelIndex, sample: s});
    modelIndex = (modelIndex == indexT'(FRAME_LEN - 1)) ? '0 : modelIndex + 1'b1;
  endtask

  task automatic driveIdle(input int cycles);
    repeat (cycles)
    begin
      @(posedge CLK);
      inValid  <= 1'b0;
      inSample <= '0;
    end
  endtask

  task automatic advanceTo(input indexT target);
    while (modelIndex != target)
      driveSample(randomSample());
  endtask

  task automatic waitDrain;
    int cycles;
    cycles = 0;
    while (expQ.size() != 0 && cycles < 20)
    begin
      driveIdle(1);
      cycles++;
    end
    if (expQ.size() != 0)
    begin
      $display("Timeout: %0d results still pending", expQ.size());
      stopRun();
    end
  endtask

  task automatic checkLatency(input complexT s);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    driveSample(s);
    while (!seen && cycles < 10)
    begin
      driveIdle(1);
      cycles++;
      @(negedge CLK);
      seen = outValid;
    end
    if (!seen)
    begin
      $display("Timeout: outValid did not rise within %0d cycles", cycles);
      stopRun();
    end
    else if (cycles != 4)
    begin
      $display("[ERROR] %0t outValid latency got %0d expected 4", $time, cycles);
      stopRun();
    end
  endtask

  initial
  begin
    void'($urandom(66));
    ARST       = 1'b1;
    inValid    = 1'b0;
    inSample   = '0;
    modelIndex = '0;
    repeat (5) @(posedge CLK);
    ARST <= 1'b0;

    // Quiet after reset
    for (int n = 0; n < 20; n++)
    begin
      @(negedge CLK);
      compareFlag("outValid", outValid, 1'b0);
    end

    // Reference against the quarter-turn rules
    probe = '{re: sampleT'(1234), im: sampleT'(-567)};
    compareSample("rotateRef index 0", rotateRef(probe, indexT'(0)), probe);
    compareSample("rotateRef index 6", rotateRef(probe, indexT'(6)),
                  '{re: probe.im, im: -probe.re});
    driveSample(probe);
    advanceTo(indexT'(6));
    driveSample(probe);
    waitDrain();

    // Three back-to-back frames
    advanceTo(indexT'(0));
    repeat (3 * FRAME_LEN)
      driveSample(randomSample());
    waitDrain();

    // Gaps in the strobe
    for (int n = 0; n < 120; n++)
    begin
      if ($urandom % 3 != 0)
        driveSample(randomSample());
      else
        driveIdle(1);
    end
    waitDrain();

    // Full scale on the diagonal twiddle
    compareSample("rotateRef saturation high",
                  rotateRef('{re: sampleT'(32767), im: sampleT'(32767)}, indexT'(21)),
                  '{re: sampleT'(0), im: sampleT'(32767)});
    compareSample("rotateRef saturation low",
                  rotateRef('{re: sampleT'(-32768), im: sampleT'(32767)}, indexT'(21)),
                  '{re: sampleT'(-32768), im: sampleT'(-1)});
    advanceTo(indexT'(21));
    driveSample('{re: sampleT'(32767), im: sampleT'(32767)});
    advanceTo(indexT'(21));
    driveSample('{re: sampleT'(-32768), im: sampleT'(32767)});
    waitDrain();

    // Isolated samples
    repeat (5)
    begin
      driveIdle(8);
      checkLatency(randomSample());
    end

    waitDrain();
    driveIdle(5);
    if (expQ.size() == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("Results left unchecked at the end of the run");
      stopRun();
    end
  end

endmodule

// ==== build.f ====
source/fixedPointPkg.sv
source/rotatorCtrlPkg.sv
source/sampleIndexer.sv
source/twiddleRom.sv
source/complexMultiplier.sv
source/twiddleRotator.sv
verif/twiddleRotatorTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the twiddle rotator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f build.f \
  --top-module twiddleRotatorTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VtwiddleRotatorTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
